//--- hdl/panel_params.svh
`ifndef PANEL_PARAMS_SVH
`define PANEL_PARAMS_SVH

//////////////////////////////////////////////////
// Front panel build constants
//////////////////////////////////////////////////

// clk cycles per scan tick
// Small for simulation, about 20000 on the board
`define PANEL_SCAN_DIV 8

// Equal scan-tick samples needed to accept a new button level
`define PANEL_DEBOUNCE_LEN 4

// Digits on the display
`define PANEL_NUM_DIGITS 8

`endif

//--- hdl/panel_pkg.sv
`default_nettype none

//////////////////////////////////////////////////
// Shared types for the debug front panel
//////////////////////////////////////////////////

package panel_pkg;

    // One processor trace word (pc, instr, dataadr, writedata, disp_data)
    typedef logic [31:0] trace_word_t;

    // Value shown on one bank of four digits
    typedef logic [15:0] halfword_t;

    // Single hex digit
    typedef logic [3:0] nibble_t;

    // Segment pattern, active low
    // Bits 6:0 are segments g..a, bit 7 is the decimal point
    typedef logic [7:0] seg_pattern_t;

    // Index of the digit being driven
    typedef logic [2:0] digit_idx_t;

    // Switches 7:5, picks the halfword for the right bank
    typedef logic [2:0] trace_sel_t;

endpackage

`default_nettype wire

//--- hdl/scan_tick_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "panel_params.svh"

module scan_tick_gen (
    input  logic clk,
    input  logic rst_n,
    output logic scan_tick
);

    // Counter wide enough for PANEL_SCAN_DIV-1
    localparam int CNT_W = (`PANEL_SCAN_DIV > 2) ? $clog2(`PANEL_SCAN_DIV) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`PANEL_SCAN_DIV - 1);

    logic [CNT_W-1:0] cnt;

    // Down-counter, reload on zero
    // Starts at the reload value so the first tick is a full period out
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt <= RELOAD;
        end
        else if (cnt == '0)
        begin
            cnt <= RELOAD;
        end
        else
        begin
            cnt <= cnt - 1'b1;
        end
    end

    // One-cycle enable in the last cycle of each period
    assign scan_tick = (cnt == '0);

endmodule

`default_nettype wire

//--- hdl/step_debounce.sv
`timescale 1ns/100ps
`default_nettype none

`include "panel_params.svh"

module step_debounce (
    input  logic clk,
    input  logic rst_n,
    input  logic scan_tick,
    input  logic pb,
    output logic step
);

    localparam int CNT_W = (`PANEL_DEBOUNCE_LEN > 2) ? $clog2(`PANEL_DEBOUNCE_LEN) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(`PANEL_DEBOUNCE_LEN - 1);

    logic             pb_meta;
    logic             pb_sync;
    logic             level;
    logic [CNT_W-1:0] eq_cnt;
    logic             differs;
    logic             accept;

    //////////////////////////////////////////////////
    // Two-flop synchronizer for the raw button
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pb_meta <= 1'b0;
            pb_sync <= 1'b0;
        end
        else
        begin
            pb_meta <= pb;
            pb_sync <= pb_meta;
        end
    end

    //////////////////////////////////////////////////
    // Sample counting and accepted level
    //////////////////////////////////////////////////

    // Sample disagrees with the accepted level
    assign differs = (pb_sync != level);
    // Last of LEN consecutive differing samples
    assign accept  = scan_tick && differs && (eq_cnt == LAST);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            eq_cnt <= '0;
            level  <= 1'b0;
            step   <= 1'b0;
        end
        else
        begin
            // Strobe lasts one cycle, only on a new high level
            step <= accept && pb_sync;
            if (scan_tick)
            begin
                if (!differs)
                begin
                    // Bounce back to the old level restarts the count
                    eq_cnt <= '0;
                end
                else if (accept)
                begin
                    level  <= pb_sync;
                    eq_cnt <= '0;
                end
                else
                begin
                    eq_cnt <= eq_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/trace_select.sv
`timescale 1ns/100ps
`default_nettype none

module trace_select (
    input  logic                   clk,
    input  logic                   rst_n,
    input  panel_pkg::trace_sel_t  trace_sel,
    input  panel_pkg::trace_word_t disp_data,
    input  panel_pkg::trace_word_t instr,
    input  panel_pkg::trace_word_t dataadr,
    input  panel_pkg::trace_word_t writedata,
    output panel_pkg::halfword_t   shown_half
);

    import panel_pkg::*;

    halfword_t next_half;

    // Even codes pick the low half, odd codes the high half
    always_comb
    begin
        case (trace_sel)
            3'b000:  next_half = disp_data[15:0];
            3'b001:  next_half = disp_data[31:16];
            3'b010:  next_half = instr[15:0];
            3'b011:  next_half = instr[31:16];
            3'b100:  next_half = dataadr[15:0];
            3'b101:  next_half = dataadr[31:16];
            3'b110:  next_half = writedata[15:0];
            default: next_half = writedata[31:16];
        endcase
    end

    // One cycle from switches and trace words to the display bank
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shown_half <= '0;
        end
        else
        begin
            shown_half <= next_half;
        end
    end

endmodule

`default_nettype wire

//--- hdl/hex_to_7seg.sv
`timescale 1ns/100ps
`default_nettype none

module hex_to_7seg (
    input  panel_pkg::nibble_t      nibble,
    output panel_pkg::seg_pattern_t seg
);

    // Active low, bit 7 is the decimal point and stays high
    // Lower-case b and d keep them apart from 8 and 0
    always_comb
    begin
        seg = 8'hFF;
        case (nibble)
            4'h0: seg = 8'hC0;
            4'h1: seg = 8'hF9;
            4'h2: seg = 8'hA4;
            4'h3: seg = 8'hB0;
            4'h4: seg = 8'h99;
            4'h5: seg = 8'h92;
            4'h6: seg = 8'h82;
            4'h7: seg = 8'hF8;
            4'h8: seg = 8'h80;
            4'h9: seg = 8'h90;
            4'hA: seg = 8'h88;
            4'hB: seg = 8'h83;
            4'hC: seg = 8'hC6;
            4'hD: seg = 8'hA1;
            4'hE: seg = 8'h86;
            4'hF: seg = 8'h8E;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/digit_scan_mux.sv
`timescale 1ns/100ps
`default_nettype none

`include "panel_params.svh"

module digit_scan_mux (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         scan_tick,
    input  panel_pkg::halfword_t         pc_low,
    input  panel_pkg::halfword_t         shown_half,
    output logic [`PANEL_NUM_DIGITS-1:0] led_sel,
    output panel_pkg::seg_pattern_t      led_seg
);

    import panel_pkg::*;

    localparam logic [`PANEL_NUM_DIGITS-1:0] ONE_BIT = `PANEL_NUM_DIGITS'(1);

    digit_idx_t   idx;
    digit_idx_t   next_idx;
    halfword_t    bank;
    nibble_t      nibble;
    seg_pattern_t pattern;

    //////////////////////////////////////////////////
    // Nibble for the digit about to be driven
    //////////////////////////////////////////////////

    // Index wraps 7 to 0 on its own width
    assign next_idx = idx + 1'b1;

    // Left bank is pc, right bank is the selected halfword
    assign bank = next_idx[2] ? shown_half : pc_low;

    // Leftmost digit of a bank carries the top nibble
    always_comb
    begin
        case (next_idx[1:0])
            2'd0:    nibble = bank[15:12];
            2'd1:    nibble = bank[11:8];
            2'd2:    nibble = bank[7:4];
            default: nibble = bank[3:0];
        endcase
    end

    // Single shared decoder
    hex_to_7seg u_hex_to_7seg (
        .nibble (nibble),
        .seg    (pattern)
    );

    //////////////////////////////////////////////////
    // Index and registered outputs
    //////////////////////////////////////////////////

    // Select and segments change on the same edge
    // Index starts at 7 so the first tick lands on digit 0
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            idx     <= 3'd7;
            led_sel <= '1;
            led_seg <= '1;
        end
        else if (scan_tick)
        begin
            idx     <= next_idx;
            // Active low one-hot select
            led_sel <= ~(ONE_BIT << next_idx);
            led_seg <= pattern;
        end
    end

endmodule

`default_nettype wire

//--- hdl/debug_panel_top.sv
`timescale 1ns/100ps
`default_nettype none

module debug_panel_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pb,
    input  logic [7:0]              switches,
    input  panel_pkg::trace_word_t  pc,
    input  panel_pkg::trace_word_t  instr,
    input  panel_pkg::trace_word_t  dataadr,
    input  panel_pkg::trace_word_t  writedata,
    input  panel_pkg::trace_word_t  disp_data,
    output logic                    step,
    output logic [7:0]              led_sel,
    output panel_pkg::seg_pattern_t led_seg
);

    import panel_pkg::*;

    logic      scan_tick;
    halfword_t shown_half;

    // Shared refresh and sampling enable
    scan_tick_gen u_scan_tick_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan_tick (scan_tick)
    );

    // Button to single-step strobe
    step_debounce u_step_debounce (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan_tick (scan_tick),
        .pb        (pb),
        .step      (step)
    );

    // Switches 4:0 go to the core, only 7:5 are used here
    trace_select u_trace_select (
        .clk        (clk),
        .rst_n      (rst_n),
        .trace_sel  (switches[7:5]),
        .disp_data  (disp_data),
        .instr      (instr),
        .dataadr    (dataadr),
        .writedata  (writedata),
        .shown_half (shown_half)
    );

    // Left bank shows the low half of pc
    digit_scan_mux u_digit_scan_mux (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_tick  (scan_tick),
        .pc_low     (pc[15:0]),
        .shown_half (shown_half),
        .led_sel    (led_sel),
        .led_seg    (led_seg)
    );

endmodule

`default_nettype wire

//--- tb/tb_debug_panel.sv
`timescale 1ns/100ps
`default_nettype none

`include "panel_params.svh"

module tb_debug_panel;

    import panel_pkg::*;

    localparam int DIV  = `PANEL_SCAN_DIV;
    localparam int LEN  = `PANEL_DEBOUNCE_LEN;
    localparam int NDIG = `PANEL_NUM_DIGITS;
    // Press to step bound including synchronizer and output flop
    localparam int STEP_LIMIT = (LEN + 1) * DIV + 3;
    // Time the button is held down, and then released, for a clean press
    localparam int HOLD = (LEN + 2) * DIV;

    // DUT ports
    logic         clk;
    logic         rst_n;
    logic         pb;
    logic [7:0]   switches;
    trace_word_t  pc;
    trace_word_t  instr;
    trace_word_t  dataadr;
    trace_word_t  writedata;
    trace_word_t  disp_data;
    logic         step;
    logic [7:0]   led_sel;
    seg_pattern_t led_seg;

    // Testbench state
    logic [31:0]  lfsr_state;
    logic         content_check;
    int           change_count;
    int           digit_seen [NDIG];
    int           step_count;
    logic         step_prev;
    digit_idx_t   prev_idx;
    logic [7:0]   prev_sel;

    debug_panel_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .pb        (pb),
        .switches  (switches),
        .pc        (pc),
        .instr     (instr),
        .dataadr   (dataadr),
        .writedata (writedata),
        .disp_data (disp_data),
        .step      (step),
        .led_sel   (led_sel),
        .led_seg   (led_seg)
    );

    // 10 ns clock
    initial clk = 1'b0;
    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers and reference model
    //////////////////////////////////////////////////

    task automatic stop_on_error();
        $display("Verification failed");
        $fatal(1, "Stopped at the first error");
    endtask

    // Right-shifting Galois LFSR with maximal-length taps
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'hB4BC_D35C;
        return n;
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // Standard digit shapes as gfedcba with 1 meaning lit
    function automatic seg_pattern_t expected_segments(input nibble_t n);
        logic [6:0] lit;
        case (n)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        // Pins are active low and the decimal point stays dark
        return {1'b1, ~lit};
    endfunction

    // Nibble a digit should show for the given inputs
    function automatic nibble_t expected_nibble(input digit_idx_t idx, input logic [7:0] sw);
        trace_word_t word;
        halfword_t   half;
        halfword_t   bank;
        int          pos;
        // Switches 7:6 pick the word and switch 5 the half
        case (sw[7:6])
            2'd0:    word = disp_data;
            2'd1:    word = instr;
            2'd2:    word = dataadr;
            default: word = writedata;
        endcase
        half = sw[5] ? word[31:16] : word[15:0];
        bank = (idx < 4) ? pc[15:0] : half;
        // Leftmost digit of each bank holds the top nibble
        pos = 12 - 4 * idx[1:0];
        return bank[pos +: 4];
    endfunction

    // Position of the single low bit
    function automatic digit_idx_t low_bit_index(input logic [7:0] sel);
        digit_idx_t found;
        found = '0;
        for (int k = 0; k < NDIG; k++)
        begin
            if (!sel[k])
                found = digit_idx_t'(k);
        end
        return found;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Fresh trace words and a switch code with sel on bits 7:5
    task automatic load_trace_words(input trace_sel_t sel);
        logic [31:0] r;
        take_bits(32, r);
        pc = r;
        take_bits(32, r);
        instr = r;
        take_bits(32, r);
        dataadr = r;
        take_bits(32, r);
        writedata = r;
        take_bits(32, r);
        disp_data = r;
        // Low switches are don't care here
        take_bits(5, r);
        switches = {sel, r[4:0]};
    endtask

    task automatic wait_scan_changes(input int n);
        int target;
        int cycles;
        target = change_count + n;
        cycles = 0;
        while (change_count < target && cycles < (n + 1) * DIV)
        begin
            next_cycle();
            cycles++;
        end
        assert (change_count >= target)
        else
        begin
            $display("Timeout at %0t: the display stopped scanning", $time);
            stop_on_error();
        end
    endtask

    task automatic wait_step_pulse(input int start, output int used);
        used = 0;
        while (step_count == start && used < STEP_LIMIT)
        begin
            next_cycle();
            used++;
        end
        assert (step_count != start)
        else
        begin
            $display("Timeout at %0t: no step pulse after the button was pressed", $time);
            stop_on_error();
        end
    endtask

    // Hold the button down and then release it for the same time
    task automatic clean_press();
        int start;
        int used;
        start = step_count;
        pb = 1'b1;
        wait_step_pulse(start, used);
        repeat (HOLD - used) next_cycle();
        pb = 1'b0;
        repeat (HOLD) next_cycle();
        assert (step_count == start + 1)
        else
        begin
            $display("Mismatch at %0t: %0d step pulses for one press, expected 1",
                     $time, step_count - start);
            stop_on_error();
        end
    endtask

    //////////////////////////////////////////////////
    // Compare process sampling on the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk)
    begin : compare
        digit_idx_t   new_idx;
        seg_pattern_t exp_seg;
        if (!rst_n)
        begin
            prev_sel  = '1;
            prev_idx  = 3'd7;
            step_prev = 1'b0;
        end
        else
        begin
            // Step must never last two cycles
            if (step)
            begin
                assert (!step_prev)
                else
                begin
                    $display("Step pulse at %0t is wider than one cycle", $time);
                    stop_on_error();
                end
                step_count++;
            end
            step_prev = step;

            if (led_sel != prev_sel)
            begin
                assert ($countones(~led_sel) == 1)
                else
                begin
                    $display("Mismatch at %0t: led_sel %b is not one-hot low",
                             $time, led_sel);
                    stop_on_error();
                end
                new_idx = low_bit_index(led_sel);
                // Scan advances by one digit and wraps 7 to 0
                assert (new_idx == digit_idx_t'(prev_idx + 1'b1))
                else
                begin
                    $display("Mismatch at %0t: digit %0d follows digit %0d",
                             $time, new_idx, prev_idx);
                    stop_on_error();
                end
                if (content_check)
                begin
                    exp_seg = expected_segments(expected_nibble(new_idx, switches));
                    assert (led_seg == exp_seg)
                    else
                    begin
                        $display("Mismatch at %0t: digit %0d led_seg %h expected %h",
                                 $time, new_idx, led_seg, exp_seg);
                        stop_on_error();
                    end
                    digit_seen[new_idx]++;
                end
                change_count++;
                prev_sel = led_sel;
                prev_idx = new_idx;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial
    begin : main
        logic [31:0] r;
        int          cycles;
        int          start;
        int          pulse_len;
        lfsr_state    = 32'hf02e273d;
        rst_n         = 1'b0;
        pb            = 1'b0;
        switches      = '0;
        pc            = '0;
        instr         = '0;
        dataadr       = '0;
        writedata     = '0;
        disp_data     = '0;
        content_check = 1'b0;
        change_count  = 0;
        step_count    = 0;
        step_prev     = 1'b0;
        prev_idx      = 3'd7;
        prev_sel      = '1;
        for (int k = 0; k < NDIG; k++)
            digit_seen[k] = 0;

        // Reset for 16 cycles
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Dark display and no step right after reset
        assert (led_sel == 8'hFF && step == 1'b0)
        else
        begin
            $display("Mismatch at %0t: led_sel %b step %b after reset", $time, led_sel, step);
            stop_on_error();
        end
        cycles = 0;
        while (led_sel == 8'hFF && cycles < DIV + 2)
        begin
            next_cycle();
            cycles++;
        end
        assert (led_sel == 8'hFE)
        else
        begin
            $display("Timeout at %0t: digit 0 was not selected after reset", $time);
            stop_on_error();
        end

        // Every switch code with random trace words
        for (int sel = 0; sel < 8; sel++)
        begin
            content_check = 1'b0;
            load_trace_words(trace_sel_t'(sel));
            // Two full scan periods to settle the selector
            repeat (2 * DIV) next_cycle();
            for (int k = 0; k < NDIG; k++)
                digit_seen[k] = 0;
            content_check = 1'b1;
            wait_scan_changes(2 * NDIG);
            for (int k = 0; k < NDIG; k++)
            begin
                assert (digit_seen[k] == 2)
                else
                begin
                    $display("Mismatch at %0t: digit %0d shown %0d times in 16 changes",
                             $time, k, digit_seen[k]);
                    stop_on_error();
                end
            end
        end
        content_check = 1'b0;

        // Single clean press
        clean_press();

        // Short bounces below the debounce length
        start = step_count;
        repeat (6)
        begin
            take_bits(2, r);
            pulse_len = (r % (LEN - 1)) + 1;
            pb = 1'b1;
            repeat (pulse_len * DIV) next_cycle();
            pb = 1'b0;
            repeat (HOLD) next_cycle();
        end
        assert (step_count == start)
        else
        begin
            $display("Mismatch at %0t: step pulsed on a bounce shorter than %0d ticks",
                     $time, LEN);
            stop_on_error();
        end
        // Still one pulse for a real press afterwards
        clean_press();

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
hdl/panel_pkg.sv
hdl/scan_tick_gen.sv
hdl/step_debounce.sv
hdl/trace_select.sv
hdl/hex_to_7seg.sv
hdl/digit_scan_mux.sv
hdl/debug_panel_top.sv
tb/tb_debug_panel.sv

//--- Bender.yml
package:
  name: debug_panel

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/panel_pkg.sv
      - hdl/scan_tick_gen.sv
      - hdl/step_debounce.sv
      - hdl/trace_select.sv
      - hdl/hex_to_7seg.sv
      - hdl/digit_scan_mux.sv
      - hdl/debug_panel_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_debug_panel.sv
